/* bcv_tile_engine.f */
hw/bcv_pkg.sv
hw/bcv_sequencer.sv
hw/bcv_loop_counter.sv
hw/nv_pingpong_buffer.sv
hw/nv_dot_unit.sv
hw/block_accumulator.sv
hw/bcv_tile_engine.sv
tests/bcv_tile_engine_asserts.sv
tests/bcv_tile_engine_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module bcv_tile_engine_tb -f bcv_tile_engine.f \
    && ./obj_dir/Vbcv_tile_engine_tb > sim.log 2>&1 \
    || echo "Errors found" >> sim.log
cat sim.log
! grep -q "Errors found" sim.log

/* tests/bcv_tile_engine_tb.sv */
`timescale 1ns/1ns

module bcv_tile_engine_tb;

    localparam int NV_LANES   = 4;
    localparam int WAIT_LIMIT = 500;

    logic                  i_clk = 1'b0;
    logic                  i_reset_n;
    logic                  i_tile_en;
    bcv_pkg::dim_t         i_dim_b;
    bcv_pkg::dim_t         i_dim_c;
    bcv_pkg::dim_t         i_dim_v;
    bcv_pkg::nv_addr_t     i_left_base;
    bcv_pkg::nv_addr_t     i_right_base;
    bcv_pkg::nv_exp_t      i_left_exp;
    bcv_pkg::nv_exp_t      i_right_exp;
    logic [NV_LANES*8-1:0] i_left_man;
    logic [NV_LANES*8-1:0] i_right_man;
    bcv_pkg::nv_addr_t     o_left_rd_idx;
    bcv_pkg::nv_addr_t     o_right_rd_idx;
    bcv_pkg::acc_man_t     o_result_man;
    bcv_pkg::nv_exp_t      o_result_exp;
    logic                  o_result_valid;
    logic                  o_tile_done;

    // Tile memory, one exponent and NV_LANES mantissas per entry
    logic [7:0]            mem_exp [128];
    logic [NV_LANES*8-1:0] mem_man [128];
    logic [31:0]           lfsr = 32'hca42ba14;

    // Combinational read, same cycle as the index
    assign i_left_exp  = mem_exp[o_left_rd_idx];
    assign i_left_man  = mem_man[o_left_rd_idx];
    assign i_right_exp = mem_exp[o_right_rd_idx];
    assign i_right_man = mem_man[o_right_rd_idx];

    always #2 i_clk = ~i_clk;

    bcv_tile_engine #(
        .NV_LANES (NV_LANES)
    ) bcv_tile_engine_i (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_tile_en      (i_tile_en),
        .i_dim_b        (i_dim_b),
        .i_dim_c        (i_dim_c),
        .i_dim_v        (i_dim_v),
        .i_left_base    (i_left_base),
        .i_right_base   (i_right_base),
        .i_left_exp     (i_left_exp),
        .i_left_man     (i_left_man),
        .i_right_exp    (i_right_exp),
        .i_right_man    (i_right_man),
        .o_left_rd_idx  (o_left_rd_idx),
        .o_right_rd_idx (o_right_rd_idx),
        .o_result_man   (o_result_man),
        .o_result_exp   (o_result_exp),
        .o_result_valid (o_result_valid),
        .o_tile_done    (o_tile_done)
    );

    // ====================
    // Helpers
    // ====================

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch at %0t: %s expected %0h actual %0h", $time, name, expected,
                     actual);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic set_nv(input int addr, input logic [31:0] man, input logic [7:0] e);
        @(posedge i_clk);
        mem_man[addr] <= man;
        mem_exp[addr] <= e;
        @(negedge i_clk);
    endtask

    // Random mantissas, exponents fixed at 1 or random in -4..3
    task automatic fill_random(input bit same_exp);
        logic [31:0] r;
        @(posedge i_clk);
        for (int a = 0; a < 128; a++) begin
            r = rand_bits(3);
            mem_man[a] <= rand_bits(32);
            mem_exp[a] <= same_exp ? 8'sd1 : {{5{r[2]}}, r[2:0]};
        end
        @(negedge i_clk);
    endtask

    // Expected (b, c) result from the memory contents
    task automatic model_result(input int b, input int c, input int v_dim, input int lb,
                                input int rb, output logic signed [31:0] man,
                                output logic signed [7:0] ea);
        int                 li;
        int                 ri;
        int                 sa;
        int                 sd;
        logic signed [31:0] dman;
        logic signed [7:0]  dexp;
        logic signed [7:0]  mx;
        for (int v = 0; v < v_dim; v++) begin
            li   = (lb + b * v_dim + v) % 128;
            ri   = (rb + c * v_dim + v) % 128;
            dman = 0;
            for (int l = 0; l < NV_LANES; l++) begin
                dman = dman + $signed(mem_man[li][l*8 +: 8]) * $signed(mem_man[ri][l*8 +: 8]);
            end
            // Exponent sum wraps at 8 bits
            dexp = mem_exp[li] + mem_exp[ri];
            if (v == 0) begin
                man = dman;
                ea  = dexp;
            end else begin
                mx  = (ea > dexp) ? ea : dexp;
                sa  = int'(mx) - int'(ea);
                sd  = int'(mx) - int'(dexp);
                // Shift of 32 or more leaves nothing
                man = ((sa >= 32) ? 0 : (man >>> sa)) + ((sd >= 32) ? 0 : (dman >>> sd));
                ea  = mx;
            end
        end
    endtask

    task automatic start_tile(input int b, input int c, input int v, input int lb,
                              input int rb);
        @(posedge i_clk);
        i_tile_en    <= 1'b1;
        i_dim_b      <= 4'(b);
        i_dim_c      <= 4'(c);
        i_dim_v      <= 4'(v);
        i_left_base  <= 7'(lb);
        i_right_base <= 7'(rb);
        @(posedge i_clk);
        i_tile_en    <= 1'b0;
    endtask

    // Start a tile, check every result in order, stop at tile done
    task automatic run_tile(input int b, input int c, input int v, input int lb, input int rb);
        logic signed [31:0] q_man [$];
        logic signed [7:0]  q_exp [$];
        logic signed [31:0] m;
        logic signed [7:0]  e;
        int                 count;
        int                 cycles;
        bit                 done;
        for (int bi = 0; bi < b; bi++) begin
            for (int ci = 0; ci < c; ci++) begin
                model_result(bi, ci, v, lb, rb, m, e);
                q_man.push_back(m);
                q_exp.push_back(e);
            end
        end
        start_tile(b, c, v, lb, rb);
        count  = 0;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge i_clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                fail_timeout("o_tile_done");
            end
            if (o_result_valid) begin
                if (count < q_man.size()) begin
                    check("o_result_man", q_man[count], o_result_man);
                    check("o_result_exp", q_exp[count], o_result_exp);
                end
                count++;
            end
            done = o_tile_done;
        end
        check("result count", b * c, count);
    endtask

    task automatic wait_result();
        int cycles;
        cycles = 0;
        do begin
            @(negedge i_clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                fail_timeout("o_result_valid");
            end
        end while (!o_result_valid);
    endtask

    task automatic check_quiet(input int n);
        repeat (n) begin
            @(negedge i_clk);
            check("o_result_valid", 0, o_result_valid);
            check("o_tile_done", 0, o_tile_done);
        end
    endtask

    // ====================
    // Directed tests
    // ====================

    // Lanes 3 -2 5 7 times 4 6 -1 2, exps 2 and -3
    task automatic single_product();
        set_nv(0, 32'h0705FE03, 8'sd2);
        set_nv(1, 32'h02FF0604, -8'sd3);
        run_tile(1, 1, 1, 0, 1);
        check("o_result_man", 9, o_result_man);
        check("o_result_exp", -1, o_result_exp);
    endtask

    task automatic accumulate_over_v();
        fill_random(1'b1);
        run_tile(1, 1, 5, 10, 40);
    endtask

    // Last pair has a dot of -1 far below the running sum and flushes
    task automatic align_exponents();
        fill_random(1'b0);
        set_nv(23, 32'h000000FF, -8'sd60);
        set_nv(63, 32'h00000001, 8'sd0);
        run_tile(1, 1, 4, 20, 60);
    endtask

    // Left base wraps past entry 127
    task automatic address_and_order();
        fill_random(1'b0);
        run_tile(3, 2, 3, 120, 37);
    endtask

    task automatic done_pulse();
        fill_random(1'b0);
        run_tile(2, 3, 2, 64, 3);
        check_quiet(40);
    endtask

    // Second edge lands after the first result of the old tile
    task automatic restart_in_flight();
        fill_random(1'b0);
        start_tile(2, 2, 4, 5, 50);
        wait_result();
        run_tile(2, 3, 2, 30, 90);
    endtask

    initial begin
        i_reset_n    = 1'b0;
        i_tile_en    = 1'b0;
        i_dim_b      = 4'd1;
        i_dim_c      = 4'd1;
        i_dim_v      = 4'd1;
        i_left_base  = '0;
        i_right_base = '0;
        for (int a = 0; a < 128; a++) begin
            mem_exp[a] = '0;
            mem_man[a] = '0;
        end
        repeat (3) @(posedge i_clk);
        i_reset_n <= 1'b1;
        single_product();
        accumulate_over_v();
        align_exponents();
        address_and_order();
        done_pulse();
        restart_in_flight();
        $display("No errors");
        $finish;
    end

endmodule

/* tests/bcv_tile_engine_asserts.sv */
`timescale 1ns/1ns

module bcv_tile_engine_asserts (
    input logic i_clk,
    input logic i_reset_n,
    input logic i_result_valid,
    input logic i_tile_done
);

    // Done is a single-cycle pulse
    done_one_cycle: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_tile_done |=> !i_tile_done)
        else $error("o_tile_done stayed high for more than one cycle");

    // Result and done never share a cycle
    result_not_with_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        !(i_result_valid && i_tile_done))
        else $error("o_result_valid and o_tile_done high together");

    // Both strobes quiet in reset
    quiet_in_reset: assert property (@(posedge i_clk)
        !i_reset_n |-> !i_result_valid && !i_tile_done)
        else $error("output strobe high during reset");

endmodule

bind bcv_tile_engine bcv_tile_engine_asserts bcv_tile_engine_asserts_i (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_result_valid (o_result_valid),
    .i_tile_done    (o_tile_done)
);

/* hw/bcv_tile_engine.sv */
`timescale 1ns/1ns

module bcv_tile_engine #(
    parameter int NV_LANES = 4
) (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_tile_en,
    input  bcv_pkg::dim_t         i_dim_b,
    input  bcv_pkg::dim_t         i_dim_c,
    input  bcv_pkg::dim_t         i_dim_v,
    input  bcv_pkg::nv_addr_t     i_left_base,
    input  bcv_pkg::nv_addr_t     i_right_base,
    input  bcv_pkg::nv_exp_t      i_left_exp,
    input  logic [NV_LANES*8-1:0] i_left_man,
    input  bcv_pkg::nv_exp_t      i_right_exp,
    input  logic [NV_LANES*8-1:0] i_right_man,
    output bcv_pkg::nv_addr_t     o_left_rd_idx,
    output bcv_pkg::nv_addr_t     o_right_rd_idx,
    output bcv_pkg::acc_man_t     o_result_man,
    output bcv_pkg::nv_exp_t      o_result_exp,
    output logic                  o_result_valid,
    output logic                  o_tile_done
);

    // Sequencer strobes
    logic start;
    logic fill_step;
    logic comp_step;
    logic fill_load;
    logic fill_sel;
    logic comp_take;
    logic comp_sel;
    logic dot_valid;
    logic accum_en;
    // Counter flags
    logic fill_avail;
    logic last_iter;
    logic v_first;
    logic v_last;
    logic ping_ready;
    logic pong_ready;
    // Selected NV pair and its dot product
    bcv_pkg::nv_exp_t      buf_left_exp;
    bcv_pkg::nv_exp_t      buf_right_exp;
    logic [NV_LANES*8-1:0] buf_left_man;
    logic [NV_LANES*8-1:0] buf_right_man;
    bcv_pkg::acc_man_t     dot_man;
    bcv_pkg::nv_exp_t      dot_exp;

    bcv_sequencer bcv_sequencer_i (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_tile_en    (i_tile_en),
        .i_fill_avail (fill_avail),
        .i_last_iter  (last_iter),
        .i_ping_ready (ping_ready),
        .i_pong_ready (pong_ready),
        .o_start      (start),
        .o_fill_step  (fill_step),
        .o_comp_step  (comp_step),
        .o_fill_load  (fill_load),
        .o_fill_sel   (fill_sel),
        .o_comp_take  (comp_take),
        .o_comp_sel   (comp_sel),
        .o_dot_valid  (dot_valid),
        .o_accum_en   (accum_en),
        .o_tile_done  (o_tile_done)
    );

    bcv_loop_counter bcv_loop_counter_i (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_start        (start),
        .i_fill_step    (fill_step),
        .i_comp_step    (comp_step),
        .i_dim_b        (i_dim_b),
        .i_dim_c        (i_dim_c),
        .i_dim_v        (i_dim_v),
        .i_left_base    (i_left_base),
        .i_right_base   (i_right_base),
        .o_fill_avail   (fill_avail),
        .o_last_iter    (last_iter),
        .o_v_first      (v_first),
        .o_v_last       (v_last),
        .o_left_rd_idx  (o_left_rd_idx),
        .o_right_rd_idx (o_right_rd_idx)
    );

    nv_pingpong_buffer #(
        .NV_LANES (NV_LANES)
    ) nv_pingpong_buffer_i (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_start      (start),
        .i_fill_load  (fill_load),
        .i_fill_sel   (fill_sel),
        .i_comp_take  (comp_take),
        .i_comp_sel   (comp_sel),
        .i_left_exp   (i_left_exp),
        .i_left_man   (i_left_man),
        .i_right_exp  (i_right_exp),
        .i_right_man  (i_right_man),
        .o_ping_ready (ping_ready),
        .o_pong_ready (pong_ready),
        .o_left_exp   (buf_left_exp),
        .o_left_man   (buf_left_man),
        .o_right_exp  (buf_right_exp),
        .o_right_man  (buf_right_man)
    );

    nv_dot_unit #(
        .NV_LANES (NV_LANES)
    ) nv_dot_unit_i (
        .i_clk       (i_clk),
        .i_reset_n   (i_reset_n),
        .i_valid     (dot_valid),
        .i_left_exp  (buf_left_exp),
        .i_left_man  (buf_left_man),
        .i_right_exp (buf_right_exp),
        .i_right_man (buf_right_man),
        .o_dot_man   (dot_man),
        .o_dot_exp   (dot_exp)
    );

    block_accumulator block_accumulator_i (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_accum_en     (accum_en),
        .i_v_first      (v_first),
        .i_v_last       (v_last),
        .i_dot_man      (dot_man),
        .i_dot_exp      (dot_exp),
        .o_result_man   (o_result_man),
        .o_result_exp   (o_result_exp),
        .o_result_valid (o_result_valid)
    );

endmodule

/* hw/block_accumulator.sv */
`timescale 1ns/1ns

module block_accumulator (
    input  logic              i_clk,
    input  logic              i_reset_n,
    input  logic              i_accum_en,
    input  logic              i_v_first,
    input  logic              i_v_last,
    input  bcv_pkg::acc_man_t i_dot_man,
    input  bcv_pkg::nv_exp_t  i_dot_exp,
    output bcv_pkg::acc_man_t o_result_man,
    output bcv_pkg::nv_exp_t  o_result_exp,
    output logic              o_result_valid
);

    bcv_pkg::acc_man_t acc_man_q;
    bcv_pkg::nv_exp_t  acc_exp_q;
    bcv_pkg::nv_exp_t  max_exp;
    logic [7:0]        diff_acc;
    logic [7:0]        diff_dot;
    bcv_pkg::acc_man_t sum_man;
    bcv_pkg::nv_exp_t  sum_exp;

    // Arithmetic right shift, flush once the shift reaches MAX_SHIFT
    function automatic bcv_pkg::acc_man_t align(input bcv_pkg::acc_man_t man,
                                                input logic [7:0] shift);
        if (shift >= bcv_pkg::MAX_SHIFT) begin
            return '0;
        end
        return man >>> shift;
    endfunction

    always_comb begin
        max_exp  = (acc_exp_q > i_dot_exp) ? acc_exp_q : i_dot_exp;
        // Differences are never negative, 0 to 255
        diff_acc = 8'(max_exp - acc_exp_q);
        diff_dot = 8'(max_exp - i_dot_exp);
        if (i_v_first) begin
            sum_man = i_dot_man;
            sum_exp = i_dot_exp;
        end else begin
            sum_man = align(acc_man_q, diff_acc) + align(i_dot_man, diff_dot);
            sum_exp = max_exp;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_accum_en) begin
            acc_man_q <= sum_man;
            acc_exp_q <= sum_exp;
            // Held until the next (b, c) finishes
            if (i_v_last) begin
                o_result_man <= sum_man;
                o_result_exp <= sum_exp;
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            o_result_valid <= 1'b0;
        end else begin
            o_result_valid <= i_accum_en && i_v_last;
        end
    end

endmodule

/* hw/nv_dot_unit.sv */
`timescale 1ns/1ns

module nv_dot_unit #(
    parameter int NV_LANES = 4
) (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_valid,
    input  bcv_pkg::nv_exp_t      i_left_exp,
    input  logic [NV_LANES*8-1:0] i_left_man,
    input  bcv_pkg::nv_exp_t      i_right_exp,
    input  logic [NV_LANES*8-1:0] i_right_man,
    output bcv_pkg::acc_man_t     o_dot_man,
    output bcv_pkg::nv_exp_t      o_dot_exp
);

    logic signed [15:0] prod_d [NV_LANES];
    logic signed [15:0] prod_q [NV_LANES];
    bcv_pkg::nv_exp_t   exp_q;
    bcv_pkg::acc_man_t  prod_sum;
    logic               valid_q;

    // Signed 8x8 product per lane
    always_comb begin
        for (int i = 0; i < NV_LANES; i++) begin
            prod_d[i] = bcv_pkg::lane_man_t'(i_left_man[i*8 +: 8])
                        * bcv_pkg::lane_man_t'(i_right_man[i*8 +: 8]);
        end
    end

    // Sign-extended lane sum
    always_comb begin
        prod_sum = '0;
        for (int i = 0; i < NV_LANES; i++) begin
            prod_sum = prod_sum + bcv_pkg::acc_man_t'(prod_q[i]);
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_valid;
        end
    end

    // Stage 1 on i_valid, stage 2 one cycle later
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            prod_q <= prod_d;
            // Exponent sum wraps at 8 bits
            exp_q  <= i_left_exp + i_right_exp;
        end
        if (valid_q) begin
            o_dot_man <= prod_sum;
            o_dot_exp <= exp_q;
        end
    end

endmodule

/* hw/nv_pingpong_buffer.sv */
`timescale 1ns/1ns

module nv_pingpong_buffer #(
    parameter int NV_LANES = 4
) (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_start,
    input  logic                  i_fill_load,
    input  logic                  i_fill_sel,
    input  logic                  i_comp_take,
    input  logic                  i_comp_sel,
    input  bcv_pkg::nv_exp_t      i_left_exp,
    input  logic [NV_LANES*8-1:0] i_left_man,
    input  bcv_pkg::nv_exp_t      i_right_exp,
    input  logic [NV_LANES*8-1:0] i_right_man,
    output logic                  o_ping_ready,
    output logic                  o_pong_ready,
    output bcv_pkg::nv_exp_t      o_left_exp,
    output logic [NV_LANES*8-1:0] o_left_man,
    output bcv_pkg::nv_exp_t      o_right_exp,
    output logic [NV_LANES*8-1:0] o_right_man
);

    // Index 0 is ping, 1 is pong
    bcv_pkg::nv_exp_t      left_exp_q  [2];
    bcv_pkg::nv_exp_t      right_exp_q [2];
    logic [NV_LANES*8-1:0] left_man_q  [2];
    logic [NV_LANES*8-1:0] right_man_q [2];
    logic [1:0]            ready_q;
    logic                  sel_q;
    logic                  rd_sel;

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            ready_q <= 2'b00;
            sel_q   <= 1'b0;
        end else if (i_start) begin
            ready_q <= 2'b00;
        end else begin
            // Load and take never hit the same side
            if (i_fill_load) begin
                ready_q[i_fill_sel] <= 1'b1;
            end
            if (i_comp_take) begin
                ready_q[i_comp_sel] <= 1'b0;
                sel_q               <= i_comp_sel;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_fill_load) begin
            left_exp_q[i_fill_sel]  <= i_left_exp;
            left_man_q[i_fill_sel]  <= i_left_man;
            right_exp_q[i_fill_sel] <= i_right_exp;
            right_man_q[i_fill_sel] <= i_right_man;
        end
    end

    // New selection shows already in the take cycle
    assign rd_sel       = i_comp_take ? i_comp_sel : sel_q;
    assign o_left_exp   = left_exp_q[rd_sel];
    assign o_left_man   = left_man_q[rd_sel];
    assign o_right_exp  = right_exp_q[rd_sel];
    assign o_right_man  = right_man_q[rd_sel];
    assign o_ping_ready = ready_q[0];
    assign o_pong_ready = ready_q[1];

endmodule

/* hw/bcv_loop_counter.sv */
`timescale 1ns/1ns

module bcv_loop_counter (
    input  logic              i_clk,
    input  logic              i_reset_n,
    input  logic              i_start,
    input  logic              i_fill_step,
    input  logic              i_comp_step,
    input  bcv_pkg::dim_t     i_dim_b,
    input  bcv_pkg::dim_t     i_dim_c,
    input  bcv_pkg::dim_t     i_dim_v,
    input  bcv_pkg::nv_addr_t i_left_base,
    input  bcv_pkg::nv_addr_t i_right_base,
    output logic              o_fill_avail,
    output logic              o_last_iter,
    output logic              o_v_first,
    output logic              o_v_last,
    output bcv_pkg::nv_addr_t o_left_rd_idx,
    output bcv_pkg::nv_addr_t o_right_rd_idx
);

    bcv_pkg::dim_t     dim_c_q;
    bcv_pkg::dim_t     dim_v_q;
    bcv_pkg::nv_addr_t left_base_q;
    bcv_pkg::nv_addr_t right_base_q;
    bcv_pkg::flat_t    total_q;

    // Flat cursors, fill b/c/v position and compute v
    bcv_pkg::flat_t fill_cnt;
    bcv_pkg::flat_t comp_cnt;
    bcv_pkg::dim_t  fill_b;
    bcv_pkg::dim_t  fill_c;
    bcv_pkg::dim_t  fill_v;
    bcv_pkg::dim_t  comp_v;

    logic [7:0] left_off;
    logic [7:0] right_off;

    // Next {b, c, v}, v carries into c, c carries into b
    function automatic logic [11:0] step_pos(input bcv_pkg::dim_t b, input bcv_pkg::dim_t c,
                                             input bcv_pkg::dim_t v);
        if (v != dim_v_q - 4'd1) begin
            return {b, c, v + 4'd1};
        end
        if (c != dim_c_q - 4'd1) begin
            return {b, c + 4'd1, 4'd0};
        end
        return {b + 4'd1, 8'd0};
    endfunction

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            dim_c_q      <= '0;
            dim_v_q      <= '0;
            left_base_q  <= '0;
            right_base_q <= '0;
            total_q      <= '0;
            fill_cnt     <= '0;
            comp_cnt     <= '0;
            {fill_b, fill_c, fill_v} <= '0;
            comp_v       <= '0;
        end else if (i_start) begin
            // Capture the command, rewind both cursors
            dim_c_q      <= i_dim_c;
            dim_v_q      <= i_dim_v;
            left_base_q  <= i_left_base;
            right_base_q <= i_right_base;
            total_q      <= bcv_pkg::flat_t'(i_dim_b) * bcv_pkg::flat_t'(i_dim_c)
                            * bcv_pkg::flat_t'(i_dim_v);
            fill_cnt     <= '0;
            comp_cnt     <= '0;
            {fill_b, fill_c, fill_v} <= '0;
            comp_v       <= '0;
        end else begin
            if (i_fill_step) begin
                fill_cnt <= fill_cnt + 12'd1;
                {fill_b, fill_c, fill_v} <= step_pos(fill_b, fill_c, fill_v);
            end
            if (i_comp_step) begin
                comp_cnt <= comp_cnt + 12'd1;
                // Accumulator flags only look at v
                comp_v   <= (comp_v == dim_v_q - 4'd1) ? 4'd0 : comp_v + 4'd1;
            end
        end
    end

    // Fill stays below the total and at most one ahead of compute
    assign o_fill_avail = (fill_cnt < total_q) && (fill_cnt <= comp_cnt + 12'd1);
    assign o_last_iter  = comp_cnt == total_q - 12'd1;
    assign o_v_first    = comp_v == 4'd0;
    assign o_v_last     = comp_v == dim_v_q - 4'd1;

    // Offsets b*V + v and c*V + v, read index wraps at 128
    assign left_off       = 8'(fill_b) * 8'(dim_v_q) + 8'(fill_v);
    assign right_off      = 8'(fill_c) * 8'(dim_v_q) + 8'(fill_v);
    assign o_left_rd_idx  = left_base_q + left_off[6:0];
    assign o_right_rd_idx = right_base_q + right_off[6:0];

endmodule

/* hw/bcv_sequencer.sv */
`timescale 1ns/1ns

module bcv_sequencer (
    input  logic i_clk,
    input  logic i_reset_n,
    input  logic i_tile_en,
    input  logic i_fill_avail,
    input  logic i_last_iter,
    input  logic i_ping_ready,
    input  logic i_pong_ready,
    output logic o_start,
    output logic o_fill_step,
    output logic o_comp_step,
    output logic o_fill_load,
    output logic o_fill_sel,
    output logic o_comp_take,
    output logic o_comp_sel,
    output logic o_dot_valid,
    output logic o_accum_en,
    output logic o_tile_done
);

    localparam int NV_CNT_W = $clog2(bcv_pkg::COMP_NV_CYCLES);

    bcv_pkg::fill_state_t fill_state;
    bcv_pkg::fill_state_t fill_next;
    bcv_pkg::comp_state_t comp_state;
    bcv_pkg::comp_state_t comp_next;

    logic                tile_en_q;
    logic                tile_rise;
    // Edge cycle plus start cycle, old tile is being torn down
    logic                flush;
    logic                tile_complete;
    logic                fill_sel_q;
    logic [NV_CNT_W-1:0] nv_cnt;

    assign tile_rise = i_tile_en & ~tile_en_q;
    assign flush     = tile_rise | o_start;

    // ====================
    // Fill FSM
    // ====================
    always_comb begin
        fill_next = fill_state;
        if (flush) begin
            fill_next = bcv_pkg::FILL_IDLE;
        end else begin
            case (fill_state)
                // Need a free side and an allowed iteration
                bcv_pkg::FILL_IDLE: begin
                    if (i_fill_avail && !(i_ping_ready && i_pong_ready)) begin
                        fill_next = bcv_pkg::FILL_ACTIVE;
                    end
                end
                // Single-cycle load
                default: fill_next = bcv_pkg::FILL_IDLE;
            endcase
        end
    end

    // ====================
    // Compute FSM
    // ====================
    always_comb begin
        comp_next = comp_state;
        if (flush) begin
            comp_next = bcv_pkg::COMP_IDLE;
        end else begin
            case (comp_state)
                bcv_pkg::COMP_IDLE: begin
                    // No restart once the tile has finished
                    if ((i_ping_ready || i_pong_ready) && !tile_complete) begin
                        comp_next = bcv_pkg::COMP_NV;
                    end
                end
                bcv_pkg::COMP_NV: begin
                    if (nv_cnt == NV_CNT_W'(bcv_pkg::COMP_NV_CYCLES - 1)) begin
                        comp_next = bcv_pkg::COMP_ACCUM;
                    end
                end
                bcv_pkg::COMP_ACCUM: begin
                    comp_next = i_last_iter ? bcv_pkg::COMP_DONE : bcv_pkg::COMP_IDLE;
                end
                default: comp_next = bcv_pkg::COMP_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk or negedge i_reset_n) begin
        if (!i_reset_n) begin
            tile_en_q     <= 1'b0;
            o_start       <= 1'b0;
            fill_state    <= bcv_pkg::FILL_IDLE;
            comp_state    <= bcv_pkg::COMP_IDLE;
            fill_sel_q    <= 1'b0;
            nv_cnt        <= '0;
            tile_complete <= 1'b0;
            o_tile_done   <= 1'b0;
        end else begin
            tile_en_q  <= i_tile_en;
            o_start    <= tile_rise;
            fill_state <= fill_next;
            comp_state <= comp_next;
            // Ping when free, otherwise pong
            if (fill_state == bcv_pkg::FILL_IDLE && fill_next == bcv_pkg::FILL_ACTIVE) begin
                fill_sel_q <= i_ping_ready;
            end
            // Window counter, wraps to zero after the last NV cycle
            if (comp_state == bcv_pkg::COMP_NV) begin
                nv_cnt <= nv_cnt + 1'b1;
            end else begin
                nv_cnt <= '0;
            end
            if (o_start) begin
                tile_complete <= 1'b0;
            end else if (comp_state == bcv_pkg::COMP_DONE) begin
                tile_complete <= 1'b1;
            end
            // Done one cycle after COMP_DONE, behind the last result
            o_tile_done <= !flush && comp_state == bcv_pkg::COMP_DONE;
        end
    end

    // ====================
    // Strobes
    // ====================
    assign o_fill_load = !flush && fill_state == bcv_pkg::FILL_ACTIVE;
    assign o_fill_step = o_fill_load;
    assign o_fill_sel  = fill_sel_q;

    // Take on the IDLE to NV transition, pong wins a tie
    assign o_comp_take = comp_state == bcv_pkg::COMP_IDLE && comp_next == bcv_pkg::COMP_NV;
    assign o_comp_sel  = i_pong_ready;

    assign o_dot_valid = !flush && comp_state == bcv_pkg::COMP_NV && nv_cnt == '0;
    assign o_accum_en  = !flush && comp_state == bcv_pkg::COMP_ACCUM;
    assign o_comp_step = o_accum_en;

endmodule

/* hw/bcv_pkg.sv */
package bcv_pkg;

    // ====================
    // Widths
    // ====================

    // Tile dimension or loop index, 1 to 15
    typedef logic [3:0] dim_t;
    // Flat iteration count, up to B*C*V
    typedef logic [11:0] flat_t;
    // NV index into tile memory
    typedef logic [6:0] nv_addr_t;
    // Signed block exponent
    typedef logic signed [7:0] nv_exp_t;
    // Signed dot or accumulated mantissa
    typedef logic signed [31:0] acc_man_t;
    // One signed lane mantissa
    typedef logic signed [7:0] lane_man_t;

    // ====================
    // FSM states
    // ====================

    typedef enum logic [1:0] {
        COMP_IDLE,
        COMP_NV,
        COMP_ACCUM,
        COMP_DONE
    } comp_state_t;

    typedef enum logic [0:0] {
        FILL_IDLE,
        FILL_ACTIVE
    } fill_state_t;

    // Fixed compute window per iteration
    localparam int unsigned COMP_NV_CYCLES = 4;
    // Alignment shift that flushes a mantissa to zero
    localparam int unsigned MAX_SHIFT = 32;

endpackage
